// File: hdl/cardEnumerator.sv
// card enumerator: masks out the dealt cards and walks every two-card board
`timescale 1ns/1ps
`default_nettype none

module cardEnumerator #(
    parameter int playerCount = 9
) (
    input  wire                                         clk,
    input  wire                                         rst_n,
    input  wire                                         inValid,
    input  cardPkg::cardNum  [2*playerCount-1:0]        inHoleNum,
    input  cardPkg::cardSuit [2*playerCount-1:0]        inHoleSuit,
    input  cardPkg::cardNum  [cardPkg::PubKnown-1:0]    inPubNum,
    input  cardPkg::cardSuit [cardPkg::PubKnown-1:0]    inPubSuit,
    output logic                                        boardValid,
    output logic                                        boardLast,
    output cardPkg::cardNum                             boardNumA,
    output cardPkg::cardSuit                            boardSuitA,
    output cardPkg::cardNum                             boardNumB,
    output cardPkg::cardSuit                            boardSuitB,
    output cardPkg::cardNum  [2*playerCount-1:0]        heldHoleNum,
    output cardPkg::cardSuit [2*playerCount-1:0]        heldHoleSuit,
    output cardPkg::cardNum  [cardPkg::PubKnown-1:0]    heldPubNum,
    output cardPkg::cardSuit [cardPkg::PubKnown-1:0]    heldPubSuit
);

    winRatePkg::calcState state;
    cardPkg::deckMask     initMask;
    cardPkg::deckMask     outerMask;
    cardPkg::deckMask     innerMask;
    cardPkg::deckMask     outerNext;
    cardPkg::deckMask     innerNext;
    cardPkg::cardIndex    outerIdx;
    cardPkg::cardIndex    innerIdx;
    logic                 accept;
    logic                 lastPair;

    // clear the lowest set bit
    function automatic cardPkg::deckMask dropLow(cardPkg::deckMask m);
        return m & (m - 1'b1);
    endfunction

    function automatic cardPkg::cardIndex lowIndex(cardPkg::deckMask m);
        cardPkg::cardIndex idx;
        idx = '0;
        for (int i = cardPkg::DeckSize - 1; i >= 0; i--) begin
            if (m[i]) begin
                idx = cardPkg::cardIndex'(i);
            end
        end
        return idx;
    endfunction

    // suits are 13 positions apart
    function automatic cardPkg::cardSuit idxSuit(cardPkg::cardIndex idx);
        return (idx >= 6'd39) ? 2'd3 : (idx >= 6'd26) ? 2'd2 : (idx >= 6'd13) ? 2'd1 : 2'd0;
    endfunction

    function automatic cardPkg::cardNum idxNum(cardPkg::cardIndex idx);
        return cardPkg::cardNum'(idx - idxSuit(idx) * 6'd13 + 6'd2);
    endfunction

    // ========================================
    // unseen cards
    // ========================================

    always_comb begin
        initMask = '1;
        for (int i = 0; i < 2 * playerCount; i++) begin
            initMask[cardPkg::toIndex(inHoleNum[i], inHoleSuit[i])] = 1'b0;
        end
        for (int i = 0; i < cardPkg::PubKnown; i++) begin
            initMask[cardPkg::toIndex(inPubNum[i], inPubSuit[i])] = 1'b0;
        end
    end

    assign accept    = (state == winRatePkg::Idle) && inValid;
    assign outerNext = dropLow(outerMask);
    assign innerNext = dropLow(innerMask);
    // inner walk done and no card left to pair after the next outer
    assign lastPair  = (innerNext == '0) && (dropLow(outerNext) == '0);

    // ========================================
    // FSM and walk
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= winRatePkg::Idle;
        end else begin
            case (state)
                winRatePkg::Idle: begin
                    if (inValid) begin
                        state <= winRatePkg::Enumerating;
                    end
                end
                winRatePkg::Enumerating: begin
                    if (lastPair) begin
                        state <= winRatePkg::Reporting;
                    end
                end
                default: begin
                    state <= winRatePkg::Idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            outerMask    <= initMask;
            innerMask    <= dropLow(initMask);
            heldHoleNum  <= inHoleNum;
            heldHoleSuit <= inHoleSuit;
            heldPubNum   <= inPubNum;
            heldPubSuit  <= inPubSuit;
        end else if (state == winRatePkg::Enumerating) begin
            if (innerNext == '0) begin
                // retire the outer card, restart above the new one
                outerMask <= outerNext;
                innerMask <= dropLow(outerNext);
            end else begin
                innerMask <= innerNext;
            end
        end
    end

    // outer card is the lowest remaining, inner walks the higher ones
    assign outerIdx   = lowIndex(outerMask);
    assign innerIdx   = lowIndex(innerMask);
    assign boardNumA  = idxNum(outerIdx);
    assign boardSuitA = idxSuit(outerIdx);
    assign boardNumB  = idxNum(innerIdx);
    assign boardSuitB = idxSuit(innerIdx);
    assign boardValid = (state == winRatePkg::Enumerating);
    assign boardLast  = boardValid && lastPair;

endmodule

`default_nettype wire

// File: hdl/cardPkg.sv
// card package: card number, suit and deck-position types with the index rule
`default_nettype none

package cardPkg;

    // ========================================
    // card fields
    // ========================================

    // 2 to 14, ace high
    typedef logic [3:0] cardNum;

    // 0 to 3
    typedef logic [1:0] cardSuit;

    // ========================================
    // deck positions
    // ========================================

    // suit * 13 + number - 2, so 0 to 51
    typedef logic [5:0] cardIndex;

    // one bit per deck position
    typedef logic [51:0] deckMask;

    localparam int DeckSize = 52;

    // flop, turn and river minus the two enumerated cards
    localparam int PubKnown = 3;

    // card to deck position
    function automatic cardIndex toIndex(cardNum num, cardSuit suit);
        return cardIndex'(suit * 6'd13 + num - 6'd2);
    endfunction

endpackage

`default_nettype wire

// File: hdl/showdownJudge.sv
// showdown judge: scores every player on one board and registers the winners
`timescale 1ns/1ps
`default_nettype none

module showdownJudge #(
    parameter int playerCount = 9
) (
    input  wire                                         clk,
    input  wire                                         rst_n,
    input  wire                                         boardValid,
    input  wire                                         boardLast,
    input  cardPkg::cardNum                             boardNumA,
    input  cardPkg::cardSuit                            boardSuitA,
    input  cardPkg::cardNum                             boardNumB,
    input  cardPkg::cardSuit                            boardSuitB,
    input  cardPkg::cardNum  [2*playerCount-1:0]        heldHoleNum,
    input  cardPkg::cardSuit [2*playerCount-1:0]        heldHoleSuit,
    input  cardPkg::cardNum  [cardPkg::PubKnown-1:0]    heldPubNum,
    input  cardPkg::cardSuit [cardPkg::PubKnown-1:0]    heldPubSuit,
    output logic                                        judgedValid,
    output logic                                        judgedLast,
    output logic             [playerCount-1:0]          winners
);

    // top pair number above the higher hole card
    typedef logic [7:0] handScore;

    logic [14:0]      boardSeen;
    logic [14:0]      boardPair;
    handScore         score [playerCount];
    handScore         best;
    logic [playerCount-1:0] winNext;

    function automatic cardPkg::cardNum topPair(logic [14:0] pair);
        cardPkg::cardNum top;
        top = '0;
        for (int v = 2; v <= 14; v++) begin
            if (pair[v]) begin
                top = cardPkg::cardNum'(v);
            end
        end
        return top;
    endfunction

    // ========================================
    // shared board tally
    // ========================================

    // the rule looks at numbers only, suits travel through untouched
    always_comb begin
        cardPkg::cardNum boardCard [cardPkg::PubKnown + 2];
        for (int i = 0; i < cardPkg::PubKnown; i++) begin
            boardCard[i] = heldPubNum[i];
        end
        boardCard[cardPkg::PubKnown]     = boardNumA;
        boardCard[cardPkg::PubKnown + 1] = boardNumB;
        boardSeen = '0;
        boardPair = '0;
        for (int i = 0; i < cardPkg::PubKnown + 2; i++) begin
            boardPair = boardPair | (boardSeen & (15'd1 << boardCard[i]));
            boardSeen = boardSeen | (15'd1 << boardCard[i]);
        end
    end

    // ========================================
    // per-player score
    // ========================================

    always_comb begin
        logic [14:0]     seen;
        logic [14:0]     pair;
        cardPkg::cardNum hiHole;
        best = '0;
        for (int p = 0; p < playerCount; p++) begin
            seen = boardSeen;
            pair = boardPair;
            for (int h = 0; h < 2; h++) begin
                pair = pair | (seen & (15'd1 << heldHoleNum[2*p+h]));
                seen = seen | (15'd1 << heldHoleNum[2*p+h]);
            end
            hiHole = (heldHoleNum[2*p] > heldHoleNum[2*p+1]) ?
                     heldHoleNum[2*p] : heldHoleNum[2*p+1];
            score[p] = {topPair(pair), hiHole};
            if (score[p] > best) begin
                best = score[p];
            end
        end
        // ties on both scores share the board
        for (int p = 0; p < playerCount; p++) begin
            winNext[p] = (score[p] == best);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            judgedValid <= 1'b0;
            judgedLast  <= 1'b0;
        end else begin
            judgedValid <= boardValid;
            judgedLast  <= boardValid && boardLast;
        end
    end

    always_ff @(posedge clk) begin
        winners <= winNext;
    end

endmodule

`default_nettype wire

// File: hdl/winRate.sv
// win rate top: enumerator, showdown judge and share accumulator in a pipeline
`timescale 1ns/1ps
`default_nettype none

module winRate #(
    parameter int playerCount = 9
) (
    input  wire                                         clk,
    input  wire                                         rst_n,
    input  wire                                         inValid,
    input  cardPkg::cardNum  [2*playerCount-1:0]        inHoleNum,
    input  cardPkg::cardSuit [2*playerCount-1:0]        inHoleSuit,
    input  cardPkg::cardNum  [cardPkg::PubKnown-1:0]    inPubNum,
    input  cardPkg::cardSuit [cardPkg::PubKnown-1:0]    inPubSuit,
    output logic                                        outValid,
    output winRatePkg::ratePercent [playerCount-1:0]    outWinRate
);

    // board stage
    logic                                    boardValid;
    logic                                    boardLast;
    cardPkg::cardNum                         boardNumA;
    cardPkg::cardSuit                        boardSuitA;
    cardPkg::cardNum                         boardNumB;
    cardPkg::cardSuit                        boardSuitB;
    cardPkg::cardNum  [2*playerCount-1:0]    heldHoleNum;
    cardPkg::cardSuit [2*playerCount-1:0]    heldHoleSuit;
    cardPkg::cardNum  [cardPkg::PubKnown-1:0] heldPubNum;
    cardPkg::cardSuit [cardPkg::PubKnown-1:0] heldPubSuit;

    // judged stage
    logic                                    judgedValid;
    logic                                    judgedLast;
    logic             [playerCount-1:0]      winners;

    cardEnumerator #(
        .playerCount (playerCount)
    ) enumerator (
        .clk          (clk),
        .rst_n        (rst_n),
        .inValid      (inValid),
        .inHoleNum    (inHoleNum),
        .inHoleSuit   (inHoleSuit),
        .inPubNum     (inPubNum),
        .inPubSuit    (inPubSuit),
        .boardValid   (boardValid),
        .boardLast    (boardLast),
        .boardNumA    (boardNumA),
        .boardSuitA   (boardSuitA),
        .boardNumB    (boardNumB),
        .boardSuitB   (boardSuitB),
        .heldHoleNum  (heldHoleNum),
        .heldHoleSuit (heldHoleSuit),
        .heldPubNum   (heldPubNum),
        .heldPubSuit  (heldPubSuit)
    );

    showdownJudge #(
        .playerCount (playerCount)
    ) judge (
        .clk          (clk),
        .rst_n        (rst_n),
        .boardValid   (boardValid),
        .boardLast    (boardLast),
        .boardNumA    (boardNumA),
        .boardSuitA   (boardSuitA),
        .boardNumB    (boardNumB),
        .boardSuitB   (boardSuitB),
        .heldHoleNum  (heldHoleNum),
        .heldHoleSuit (heldHoleSuit),
        .heldPubNum   (heldPubNum),
        .heldPubSuit  (heldPubSuit),
        .judgedValid  (judgedValid),
        .judgedLast   (judgedLast),
        .winners      (winners)
    );

    winShareAccumulator #(
        .playerCount (playerCount)
    ) accumulator (
        .clk         (clk),
        .rst_n       (rst_n),
        .judgedValid (judgedValid),
        .judgedLast  (judgedLast),
        .winners     (winners),
        .outValid    (outValid),
        .outWinRate  (outWinRate)
    );

endmodule

`default_nettype wire

// File: hdl/winRatePkg.sv
// win rate package: player masks, credit widths, share constants and FSM states
`default_nettype none

package winRatePkg;

    // ========================================
    // players and credit
    // ========================================

    // one bit per player at the full table of nine
    typedef logic [8:0] playerMask;

    // credit per winner on one board
    typedef logic [11:0] shareUnit;

    // 465 boards * 2520 fits in 21 bits
    typedef logic [20:0] shareAcc;

    // floored percentage of one player
    typedef logic [6:0] ratePercent;

    // lcm of 1..9, so every split is an integer
    localparam int FullShare = 2520;

    // ========================================
    // control
    // ========================================

    typedef enum logic [1:0] {
        Idle,
        Enumerating,
        Reporting
    } calcState;

    // two-card boards drawn from the unseen cards
    function automatic int boardCount(int players);
        int unseen;
        unseen = cardPkg::DeckSize - 2 * players - cardPkg::PubKnown;
        return unseen * (unseen - 1) / 2;
    endfunction

endpackage

`default_nettype wire

// File: hdl/winShareAccumulator.sv
// win share accumulator: splits board credit among winners and reports percentages
`timescale 1ns/1ps
`default_nettype none

module winShareAccumulator #(
    parameter int playerCount = 9
) (
    input  wire                                         clk,
    input  wire                                         rst_n,
    input  wire                                         judgedValid,
    input  wire                                         judgedLast,
    input  wire              [playerCount-1:0]          winners,
    output logic                                        outValid,
    output winRatePkg::ratePercent [playerCount-1:0]    outWinRate
);

    // credit of all boards together, the 100 % mark
    localparam int TotalShare = winRatePkg::boardCount(playerCount) * winRatePkg::FullShare;

    winRatePkg::playerMask  winnersWide;
    logic [3:0]             winCount;
    winRatePkg::shareUnit   share;
    winRatePkg::shareAcc    acc     [playerCount];
    winRatePkg::shareAcc    accNext [playerCount];
    winRatePkg::ratePercent rate    [playerCount];

    assign winnersWide = winRatePkg::playerMask'(winners);

    // ========================================
    // split
    // ========================================

    always_comb begin
        winCount = '0;
        for (int p = 0; p < $bits(winRatePkg::playerMask); p++) begin
            winCount = winCount + 4'(winnersWide[p]);
        end
    end

    // constant quotients only, one per possible winner count
    always_comb begin
        share = '0;
        for (int k = 1; k <= playerCount; k++) begin
            if (winCount == 4'(k)) begin
                share = winRatePkg::shareUnit'(winRatePkg::FullShare / k);
            end
        end
    end

    // ========================================
    // accumulate and convert
    // ========================================

    always_comb begin
        for (int p = 0; p < playerCount; p++) begin
            accNext[p] = winners[p] ? acc[p] + winRatePkg::shareAcc'(share) : acc[p];
            rate[p]    = winRatePkg::ratePercent'((28'(accNext[p]) * 28'd100) / TotalShare);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < playerCount; p++) begin
                acc[p] <= '0;
            end
        end else if (outValid) begin
            // back to zero for the next deal
            for (int p = 0; p < playerCount; p++) begin
                acc[p] <= '0;
            end
        end else if (judgedValid) begin
            for (int p = 0; p < playerCount; p++) begin
                acc[p] <= accNext[p];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outValid   <= 1'b0;
            outWinRate <= '0;
        end else if (judgedValid && judgedLast) begin
            outValid <= 1'b1;
            for (int p = 0; p < playerCount; p++) begin
                outWinRate[p] <= rate[p];
            end
        end else begin
            outValid   <= 1'b0;
            outWinRate <= '0;
        end
    end

endmodule

`default_nettype wire

// File: test/winRateTb.sv
// win rate testbench: random and directed deals checked against a showdown model
`timescale 1ns/1ps
`default_nettype none

module winRateTb;

    localparam int PlayerCount = 9;
    localparam int ClkPeriod   = 20;
    localparam int RandomDeals = 20;
    localparam int Unseen      = cardPkg::DeckSize - 2 * PlayerCount - cardPkg::PubKnown;
    localparam int BoardCount  = Unseen * (Unseen - 1) / 2;
    // random deals, the directed deal and the deal with an ignored pulse
    localparam int TotalDeals  = RandomDeals + 2;

    typedef winRatePkg::ratePercent [PlayerCount-1:0] rateVec;

    logic                                     clk;
    logic                                     rst_n;
    logic                                     inValid;
    cardPkg::cardNum  [2*PlayerCount-1:0]     inHoleNum;
    cardPkg::cardSuit [2*PlayerCount-1:0]     inHoleSuit;
    cardPkg::cardNum  [cardPkg::PubKnown-1:0] inPubNum;
    cardPkg::cardSuit [cardPkg::PubKnown-1:0] inPubSuit;
    logic                                     outValid;
    rateVec                                   outWinRate;

    // current deal as deck positions
    int          hole [2*PlayerCount];
    int          pub  [cardPkg::PubKnown];
    rateVec      expQ[$];
    time         startQ[$];
    rateVec      lastRates;
    int          doneCount;
    int          mismatchCount;
    int          failCount;
    logic [31:0] lcgState;

    winRate #(
        .playerCount (PlayerCount)
    ) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .inValid    (inValid),
        .inHoleNum  (inHoleNum),
        .inHoleSuit (inHoleSuit),
        .inPubNum   (inPubNum),
        .inPubSuit  (inPubSuit),
        .outValid   (outValid),
        .outWinRate (outWinRate)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] randNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int numberOf(int idx);
        return idx % 13 + 2;
    endfunction

    // ========================================
    // reference model
    // ========================================

    function automatic rateVec refRates(input int holeCards [2*PlayerCount],
                                        input int pubCards [cardPkg::PubKnown]);
        bit     used      [cardPkg::DeckSize];
        longint credit    [PlayerCount];
        int     tally     [15];
        int     primary   [PlayerCount];
        int     secondary [PlayerCount];
        int     bestPrimary;
        int     bestSecondary;
        int     winnerTotal;
        int     hiA;
        int     hiB;
        rateVec rates;
        foreach (used[i]) used[i] = 1'b0;
        foreach (credit[p]) credit[p] = 0;
        foreach (holeCards[i]) used[holeCards[i]] = 1'b1;
        foreach (pubCards[i]) used[pubCards[i]] = 1'b1;
        for (int a = 0; a < cardPkg::DeckSize; a++) begin
            for (int b = a + 1; b < cardPkg::DeckSize; b++) begin
                if (!used[a] && !used[b]) begin
                    for (int p = 0; p < PlayerCount; p++) begin
                        foreach (tally[v]) tally[v] = 0;
                        foreach (pubCards[i]) tally[numberOf(pubCards[i])]++;
                        tally[numberOf(a)]++;
                        tally[numberOf(b)]++;
                        tally[numberOf(holeCards[2*p])]++;
                        tally[numberOf(holeCards[2*p+1])]++;
                        primary[p] = 0;
                        for (int v = 2; v <= 14; v++) begin
                            if (tally[v] >= 2) primary[p] = v;
                        end
                        hiA = numberOf(holeCards[2*p]);
                        hiB = numberOf(holeCards[2*p+1]);
                        secondary[p] = (hiA > hiB) ? hiA : hiB;
                    end
                    bestPrimary = 0;
                    foreach (primary[p]) if (primary[p] > bestPrimary) bestPrimary = primary[p];
                    bestSecondary = 0;
                    winnerTotal   = 0;
                    for (int p = 0; p < PlayerCount; p++) begin
                        if (primary[p] == bestPrimary && secondary[p] > bestSecondary) begin
                            bestSecondary = secondary[p];
                        end
                    end
                    for (int p = 0; p < PlayerCount; p++) begin
                        if (primary[p] == bestPrimary && secondary[p] == bestSecondary) begin
                            winnerTotal++;
                        end
                    end
                    for (int p = 0; p < PlayerCount; p++) begin
                        if (primary[p] == bestPrimary && secondary[p] == bestSecondary) begin
                            credit[p] += winRatePkg::FullShare / winnerTotal;
                        end
                    end
                end
            end
        end
        for (int p = 0; p < PlayerCount; p++) begin
            rates[p] = winRatePkg::ratePercent'(credit[p] * 100 /
                       (longint'(BoardCount) * winRatePkg::FullShare));
        end
        return rates;
    endfunction

    // ========================================
    // compare tasks
    // ========================================

    task automatic checkRate(input int player, input winRatePkg::ratePercent got,
                             input winRatePkg::ratePercent expected);
        if (got !== expected) begin
            mismatchCount++;
            $display("mismatch at %0t: outWinRate[%0d] got %0d expected %0d",
                     $time, player, got, expected);
        end
    endtask

    task automatic checkLatency(input int got, input int expected);
        if (got != expected) begin
            mismatchCount++;
            $display("mismatch at %0t: outValid latency got %0d cycles expected %0d",
                     $time, got, expected);
        end
    endtask

    // ========================================
    // stimulus helpers
    // ========================================

    // fisher-yates over the whole deck, first 21 cards dealt
    task automatic shuffleDeal();
        int deck [cardPkg::DeckSize];
        int j;
        int tmp;
        foreach (deck[i]) deck[i] = i;
        for (int i = cardPkg::DeckSize - 1; i > 0; i--) begin
            j = int'((randNext() >> 8) % (i + 1));
            tmp = deck[i];
            deck[i] = deck[j];
            deck[j] = tmp;
        end
        foreach (hole[k]) hole[k] = deck[k];
        foreach (pub[k]) pub[k] = deck[2 * PlayerCount + k];
    endtask

    // player 0 holds two aces, board 2 7 9 in mixed suits
    task automatic loadDirected();
        hole = '{12, 25, 1, 15, 29, 43, 6, 21, 35, 49, 11, 14, 28, 42, 4, 19, 34, 48};
        pub  = '{26, 44, 7};
    endtask

    task automatic applyCards();
        foreach (hole[k]) begin
            inHoleNum[k]  = cardPkg::cardNum'(numberOf(hole[k]));
            inHoleSuit[k] = cardPkg::cardSuit'(hole[k] / 13);
        end
        foreach (pub[k]) begin
            inPubNum[k]  = cardPkg::cardNum'(numberOf(pub[k]));
            inPubSuit[k] = cardPkg::cardSuit'(pub[k] / 13);
        end
    endtask

    task automatic startDeal();
        rateVec expected;
        expected = refRates(hole, pub);
        @(negedge clk);
        applyCards();
        inValid = 1'b1;
        expQ.push_back(expected);
        startQ.push_back($time);
        @(negedge clk);
        inValid = 1'b0;
    endtask

    // ========================================
    // compare process
    // ========================================

    initial begin
        rateVec expected;
        time    start;
        forever begin
            @(negedge clk);
            if (outValid === 1'b1) begin
                if (expQ.size() == 0) begin
                    failCount++;
                    $display("error at %0t: outValid raised with no deal pending", $time);
                end else begin
                    expected = expQ.pop_front();
                    start    = startQ.pop_front();
                    checkLatency(int'(($time - start) / ClkPeriod), BoardCount + 2);
                    for (int p = 0; p < PlayerCount; p++) begin
                        checkRate(p, outWinRate[p], expected[p]);
                    end
                end
                lastRates = outWinRate;
                doneCount++;
            end else begin
                for (int p = 0; p < PlayerCount; p++) begin
                    checkRate(p, outWinRate[p], '0);
                end
            end
        end
    end

    // watchdog
    initial begin
        #(longint'(TotalDeals + 1) * (BoardCount + 20) * ClkPeriod);
        $display("error: watchdog expired before all deals were reported");
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ========================================
    // main sequence
    // ========================================

    initial begin
        rateVec dirRates;
        int     target;
        rst_n         = 1'b0;
        inValid       = 1'b0;
        inHoleNum     = '0;
        inHoleSuit    = '0;
        inPubNum      = '0;
        inPubSuit     = '0;
        doneCount     = 0;
        mismatchCount = 0;
        failCount     = 0;
        lastRates     = '0;
        lcgState      = 32'h3703e812;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // idle outputs, checked by the compare process
        repeat (10) @(negedge clk);
        if (doneCount != 0) begin
            failCount++;
            $display("error: outValid rose before any deal was sent");
        end

        for (int d = 0; d < RandomDeals; d++) begin
            shuffleDeal();
            startDeal();
            target = doneCount + 1;
            wait (doneCount >= target);
        end

        loadDirected();
        dirRates = refRates(hole, pub);
        startDeal();
        target = doneCount + 1;
        wait (doneCount >= target);
        for (int p = 1; p < PlayerCount; p++) begin
            if (dirRates[0] <= dirRates[p] || lastRates[0] <= lastRates[p]) begin
                failCount++;
                $display("error: pair of aces is not the top rate against player %0d", p);
            end
        end

        // second pulse mid-computation must be dropped
        shuffleDeal();
        startDeal();
        target = doneCount + 1;
        repeat (5) @(negedge clk);
        shuffleDeal();
        applyCards();
        inValid = 1'b1;
        @(negedge clk);
        inValid = 1'b0;
        wait (doneCount >= target);
        // long enough for a full second walk to report
        repeat (BoardCount + 20) @(negedge clk);
        if (doneCount != target) begin
            failCount++;
            $display("error: an ignored inValid pulse produced another result");
        end

        if (expQ.size() != 0) begin
            failCount++;
            $display("error: %0d accepted deals never produced outValid", expQ.size());
        end
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatchCount, failCount, UUT.assertions.errorCount);
        if (mismatchCount == 0 && failCount == 0 && UUT.assertions.errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/winRate_assert.sv
// win rate assertions: strobe width, board count per deal and idle output checks
`timescale 1ns/1ps
`default_nettype none

module winRate_assert #(
    parameter int playerCount = 9
) (
    input  wire                                         clk,
    input  wire                                         rst_n,
    input  wire                                         inValid,
    input  wire                                         boardValid,
    input  wire                                         outValid,
    input  winRatePkg::ratePercent [playerCount-1:0]    outWinRate,
    input  winRatePkg::calcState                        enumState
);

    localparam int Unseen     = cardPkg::DeckSize - 2 * playerCount - cardPkg::PubKnown;
    localparam int BoardCount = Unseen * (Unseen - 1) / 2;

    int boardsSeen;

    // failed assertions so far
    int errorCount = 0;

    // boards issued since the last accepted deal
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            boardsSeen <= 0;
        end else if (enumState == winRatePkg::Idle && inValid) begin
            boardsSeen <= 0;
        end else if (boardValid) begin
            boardsSeen <= boardsSeen + 1;
        end
    end

    singlePulse: assert property (@(posedge clk) disable iff (!rst_n) outValid |=> !outValid)
        else begin
            $error("outValid stayed high for two cycles");
            errorCount++;
        end

    fullBoardSet: assert property (@(posedge clk) disable iff (!rst_n)
        outValid |-> boardsSeen == BoardCount)
        else begin
            $error("boardValid pulsed %0d times, expected %0d", boardsSeen, BoardCount);
            errorCount++;
        end

    quietOutput: assert property (@(posedge clk) disable iff (!rst_n) !outValid |-> outWinRate == '0)
        else begin
            $error("outWinRate nonzero while outValid is low");
            errorCount++;
        end

endmodule

bind winRate winRate_assert #(
    .playerCount (playerCount)
) assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .inValid    (inValid),
    .boardValid (boardValid),
    .outValid   (outValid),
    .outWinRate (outWinRate),
    .enumState  (enumerator.state)
);

`default_nettype wire

// File: winRate.f
hdl/cardPkg.sv
hdl/winRatePkg.sv
hdl/cardEnumerator.sv
hdl/showdownJudge.sv
hdl/winShareAccumulator.sv
hdl/winRate.sv
test/winRate_assert.sv
test/winRateTb.sv
